/* logic/arcade_config.svh */
`ifndef ARCADE_CONFIG_SVH
`define ARCADE_CONFIG_SVH

// ==============================
// Clock enables
// ==============================
`define CE_179_DIV 14 // System cycles per 1.79 MHz enable pulse

// ==============================
// Audio and video widths
// ==============================
`define DAC_WIDTH       10 // Board audio sample
`define GAME_COLOR_BITS 4  // Per channel, from the board
`define VGA_COLOR_BITS  6  // Per channel, to the VGA pins

`endif

/* logic/arcade_io_pkg.sv */
`include "arcade_config.svh"

package arcade_io_pkg;

	// Keyboard button levels, high while held
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic bomb;
		logic start1;
		logic start2;
		logic coin;
	} buttons_t;

	// Board player inputs, active low, in the board's bit order
	typedef struct packed {
		logic start;
		logic bomb;
		logic fire;
		logic left;
		logic right;
		logic up;
		logic down;
	} player_in_t;

	typedef struct packed {
		logic [`GAME_COLOR_BITS-1:0] r;
		logic [`GAME_COLOR_BITS-1:0] g;
		logic [`GAME_COLOR_BITS-1:0] b;
		logic                        hs;
		logic                        vs;
		logic                        hblank;
		logic                        vblank;
	} game_video_t;

	typedef struct packed {
		logic [`VGA_COLOR_BITS-1:0] r;
		logic [`VGA_COLOR_BITS-1:0] g;
		logic [`VGA_COLOR_BITS-1:0] b;
		logic                       hs; // Active low
		logic                       vs; // Active low
	} vga_t;

	// Dimming applied to odd lines
	typedef enum logic [1:0] {
		sl_off   = 2'd0,
		sl_pct25 = 2'd1,
		sl_pct50 = 2'd2,
		sl_pct75 = 2'd3
	} scanline_t;

endpackage

/* logic/clock_enable_gen.sv */
`timescale 1ns/1ps
`include "arcade_config.svh"

module clock_enable_gen (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_1p79
);

	localparam int DIV179_W = $clog2(`CE_179_DIV);

	logic [1:0]          div;    // Free running quarter divider
	logic [DIV179_W-1:0] div179; // Counts down to the next 1.79 MHz pulse

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div     <= '0;
			div179  <= '0;
			ce_12   <= 1'b0;
			ce_6p   <= 1'b0;
			ce_6n   <= 1'b0;
			ce_1p79 <= 1'b0;
		end else begin
			div   <= div + 2'd1;
			ce_12 <= div[0];
			ce_6p <= div[0] & ~div[1]; // Phase 1 of 4
			ce_6n <= div[0] & div[1];  // Phase 3 of 4

			if (div179 == '0) begin
				div179  <= DIV179_W'(`CE_179_DIV - 1);
				ce_1p79 <= 1'b1;
			end else begin
				div179  <= div179 - 1'b1;
				ce_1p79 <= 1'b0;
			end
		end
	end

	// Both 6 MHz phases clock the same board logic on opposite edges
	a_ce6_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_6p && ce_6n))
		else $error("ce_6p and ce_6n high in the same cycle");

endmodule

/* logic/key_decoder.sv */
`timescale 1ns/1ps

module key_decoder (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   key_strobe,
	input  logic                   key_pressed,
	input  logic [7:0]             key_code,
	output arcade_io_pkg::buttons_t btn
);

	// ==============================
	// Set-2 scan code to button
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			btn <= '0;
		end else if (key_strobe) begin
			case (key_code)
				8'h75: btn.up     <= key_pressed; // Cursor up
				8'h72: btn.down   <= key_pressed; // Cursor down
				8'h6B: btn.left   <= key_pressed; // Cursor left
				8'h74: btn.right  <= key_pressed; // Cursor right
				8'h76: btn.coin   <= key_pressed; // Escape
				8'h05: btn.start1 <= key_pressed; // F1
				8'h06: btn.start2 <= key_pressed; // F2
				8'h11: btn.bomb   <= key_pressed; // Alt
				8'h29: btn.fire   <= key_pressed; // Space
				default: begin
					// Unmapped key, state kept
				end
			endcase
		end
	end

	// Held buttons only change on a host key event
	a_btn_hold: assert property (@(posedge clk_sys) disable iff (reset)
		!key_strobe |=> $stable(btn))
		else $error("btn changed without a key strobe");

endmodule

/* logic/control_mapper.sv */
`timescale 1ns/1ps

module control_mapper (
	input  arcade_io_pkg::buttons_t   btn,
	input  logic [7:0]                joystick_0,
	input  logic [7:0]                joystick_1,
	input  logic                      rotate,
	output arcade_io_pkg::player_in_t ip_1p,
	output arcade_io_pkg::player_in_t ip_2p,
	output logic                      ip_coin1
);

	// Joystick bits: 0 right, 1 left, 2 down, 3 up, 4 fire, 5 bomb
	logic any_up, any_down, any_left, any_right;
	logic m_up, m_down, m_left, m_right;
	logic m_fire, m_bomb;

	assign any_up    = btn.up    | joystick_0[3] | joystick_1[3];
	assign any_down  = btn.down  | joystick_0[2] | joystick_1[2];
	assign any_left  = btn.left  | joystick_0[1] | joystick_1[1];
	assign any_right = btn.right | joystick_0[0] | joystick_1[0];

	assign m_fire = btn.fire | joystick_0[4] | joystick_1[4];
	assign m_bomb = btn.bomb | joystick_0[5] | joystick_1[5];

	// ==============================
	// Rotation, quarter turn when rotate is low
	// ==============================
	assign m_up    = rotate ? any_up    : any_left;
	assign m_down  = rotate ? any_down  : any_right;
	assign m_left  = rotate ? any_left  : any_down;
	assign m_right = rotate ? any_right : any_up;

	// Board expects active low, both players share movement
	assign ip_1p = ~{btn.start1, m_bomb, m_fire, m_left, m_right, m_up, m_down};
	assign ip_2p = ~{btn.start2, m_bomb, m_fire, m_left, m_right, m_up, m_down};

	assign ip_coin1 = ~btn.coin;

endmodule

/* logic/video_output.sv */
`timescale 1ns/1ps
`include "arcade_config.svh"

module video_output (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  arcade_io_pkg::game_video_t game_video,
	input  arcade_io_pkg::scanline_t   scanlines,
	output arcade_io_pkg::vga_t        vga
);

	import arcade_io_pkg::*;

	localparam int GW = `GAME_COLOR_BITS;
	localparam int VW = `VGA_COLOR_BITS;

	logic          hs_prev;
	logic          line_odd; // Toggles on every hs rising edge
	logic          blank;
	scanline_t     line_mode;
	logic [VW-1:0] r_wide;
	logic [VW-1:0] g_wide;
	logic [VW-1:0] b_wide;

	// Repeat the top bits into the new low bits
	function automatic logic [VW-1:0] widen(input logic [GW-1:0] c);
		return {c, c[GW-1 -: (VW - GW)]};
	endfunction

	function automatic logic [VW-1:0] dim(input logic [VW-1:0] c, input scanline_t mode);
		case (mode)
			sl_pct25: return c - (c >> 2); // Three quarters left
			sl_pct50: return c >> 1;
			sl_pct75: return c >> 2;       // One quarter left
			default:  return c;
		endcase
	endfunction

	assign blank     = game_video.hblank | game_video.vblank;
	assign line_mode = line_odd ? scanlines : sl_off; // Even lines at full level

	assign r_wide = blank ? '0 : widen(game_video.r);
	assign g_wide = blank ? '0 : widen(game_video.g);
	assign b_wide = blank ? '0 : widen(game_video.b);

	// ==============================
	// Output register
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hs_prev  <= 1'b0;
			line_odd <= 1'b0;
			vga      <= '0;
		end else begin
			hs_prev <= game_video.hs;
			if (game_video.hs && !hs_prev)
				line_odd <= ~line_odd; // New line starts, pixel here keeps old parity

			vga.r  <= dim(r_wide, line_mode);
			vga.g  <= dim(g_wide, line_mode);
			vga.b  <= dim(b_wide, line_mode);
			vga.hs <= ~game_video.hs;
			vga.vs <= ~game_video.vs;
		end
	end

endmodule

/* logic/sigma_delta_dac.sv */
`timescale 1ns/1ps
`include "arcade_config.svh"

module sigma_delta_dac (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [`DAC_WIDTH-1:0] sample,
	output logic                  dac_out
);

	localparam int W = `DAC_WIDTH;

	logic [W:0] acc; // Error accumulator
	logic [W:0] sum;

	assign sum = acc + {1'b0, sample};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum - {sum[W], {W{1'b0}}}; // Take back the weight of the pulse
			dac_out <= sum[W]; // Overflow is the output pulse
		end
	end

	// Each pulse leaves through dac_out and none of it stays in the accumulator
	a_acc_top_clear: assert property (@(posedge clk_sys) disable iff (reset)
		1'b1 |=> !acc[W])
		else $error("accumulator top bit set after add");

endmodule

/* logic/cabinet_io_top.sv */
`timescale 1ns/1ps
`include "arcade_config.svh"

module cabinet_io_top (
	input  logic                       clk_sys,
	input  logic                       reset,
	// Host side
	input  logic                       key_strobe,
	input  logic                       key_pressed,
	input  logic [7:0]                 key_code,
	input  logic [7:0]                 joystick_0,
	input  logic [7:0]                 joystick_1,
	input  logic                       rotate,
	input  arcade_io_pkg::scanline_t   scanlines,
	// Game board side
	input  arcade_io_pkg::game_video_t game_video,
	input  logic [`DAC_WIDTH-1:0]      game_audio,
	output logic                       ce_12,
	output logic                       ce_6p,
	output logic                       ce_6n,
	output logic                       ce_1p79,
	output arcade_io_pkg::player_in_t  ip_1p,
	output arcade_io_pkg::player_in_t  ip_2p,
	output logic                       ip_coin1,
	// Cabinet outputs
	output arcade_io_pkg::vga_t        vga,
	output logic                       audio_out
);

	import arcade_io_pkg::*;

	buttons_t btn;

	clock_enable_gen clock_enable_gen_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_12   (ce_12),
		.ce_6p   (ce_6p),
		.ce_6n   (ce_6n),
		.ce_1p79 (ce_1p79)
	);

	key_decoder key_decoder_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.btn         (btn)
	);

	control_mapper control_mapper_i (
		.btn        (btn),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.ip_1p      (ip_1p),
		.ip_2p      (ip_2p),
		.ip_coin1   (ip_coin1)
	);

	video_output video_output_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.game_video (game_video),
		.scanlines  (scanlines),
		.vga        (vga)
	);

	sigma_delta_dac sigma_delta_dac_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sample  (game_audio),
		.dac_out (audio_out)
	);

endmodule

/* verif/cabinet_io_tb.sv */
`timescale 1ns/1ps
`include "arcade_config.svh"

module cabinet_io_tb;

	import arcade_io_pkg::*;

	localparam int VIDEO_CYCLES = 250; // Per scanline mode
	localparam int TEST_CYCLES  = 4 + 200 + 400 + 400 + 4 * VIDEO_CYCLES + 3 * (5 + 1026);
	localparam int TIMEOUT_CYCLES = TEST_CYCLES + 700;

	// Nine mapped set-2 codes, then seven the decoder ignores
	localparam logic [7:0] KEY_TABLE [16] = '{
		8'h75, 8'h72, 8'h6B, 8'h74, 8'h76, 8'h05, 8'h06, 8'h11,
		8'h29, 8'h00, 8'h1C, 8'h5A, 8'h14, 8'h12, 8'h7E, 8'hF0
	};

	logic                  clk_sys;
	logic                  reset;
	logic                  key_strobe;
	logic                  key_pressed;
	logic [7:0]            key_code;
	logic [7:0]            joystick_0;
	logic [7:0]            joystick_1;
	logic                  rotate;
	scanline_t             scanlines;
	game_video_t           game_video;
	logic [`DAC_WIDTH-1:0] game_audio;
	logic                  ce_12;
	logic                  ce_6p;
	logic                  ce_6n;
	logic                  ce_1p79;
	player_in_t            ip_1p;
	player_in_t            ip_2p;
	logic                  ip_coin1;
	vga_t                  vga;
	logic                  audio_out;

	string       test_name = "reset";
	logic [31:0] rng = 32'd88649;
	int          cyc;            // Edges since reset fell
	int          gap179;         // Edges since the last 1.79 MHz pulse, -1 before the first
	int          audio_count;
	int          cycles_run = 0;
	buttons_t    ref_btn;        // Button levels seen by the host
	logic        ref_hs_prev;
	logic        ref_odd;
	vga_t        exp_vga;
	logic [3:0]  dir_in;         // Up, down, left, right
	logic [3:0]  dir_out;
	logic        any_fire;
	logic        any_bomb;
	player_in_t  exp_1p;
	player_in_t  exp_2p;
	logic [2:0]  exp_ce;
	logic [39:0] idle_state;

	cabinet_io_top cabinet_io_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report_mismatch(input string test, input logic [63:0] expected,
			input logic [63:0] actual);
		stop_with_failure($sformatf("Mismatch in %s: expected %h, actual %h",
			test, expected, actual));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [5:0] expected_channel(input logic [3:0] c, input logic blank,
			input scanline_t mode);
		int full;
		full = blank ? 0 : int'({c, c[3:2]});
		case (mode)
			sl_pct25: full = full - full / 4;
			sl_pct50: full = full / 2;
			sl_pct75: full = full / 4;
			default:  ;
		endcase
		return 6'(full);
	endfunction

	function automatic vga_t expected_vga(input game_video_t gv, input scanline_t mode);
		vga_t v;
		logic blank;
		blank = gv.hblank | gv.vblank;
		v.r   = expected_channel(gv.r, blank, mode);
		v.g   = expected_channel(gv.g, blank, mode);
		v.b   = expected_channel(gv.b, blank, mode);
		v.hs  = ~gv.hs;
		v.vs  = ~gv.vs;
		return v;
	endfunction

	task automatic apply_reset();
		@(negedge clk_sys);
		joystick_0 = '0;
		joystick_1 = '0;
		key_strobe = 1'b0;
		reset      = 1'b1;
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	// ==============================
	// Reference models
	// ==============================
	always @(posedge clk_sys) begin
		if (reset) begin
			ref_btn <= '0;
		end else if (key_strobe) begin
			case (key_code)
				8'h75:   ref_btn.up     <= key_pressed;
				8'h72:   ref_btn.down   <= key_pressed;
				8'h6B:   ref_btn.left   <= key_pressed;
				8'h74:   ref_btn.right  <= key_pressed;
				8'h76:   ref_btn.coin   <= key_pressed;
				8'h05:   ref_btn.start1 <= key_pressed;
				8'h06:   ref_btn.start2 <= key_pressed;
				8'h11:   ref_btn.bomb   <= key_pressed;
				8'h29:   ref_btn.fire   <= key_pressed;
				default: ;
			endcase
		end
	end

	assign dir_in = {ref_btn.up, ref_btn.down, ref_btn.left, ref_btn.right}
		| joystick_0[3:0] | joystick_1[3:0];
	assign dir_out  = rotate ? dir_in : {dir_in[1], dir_in[0], dir_in[2], dir_in[3]};
	assign any_fire = ref_btn.fire | joystick_0[4] | joystick_1[4];
	assign any_bomb = ref_btn.bomb | joystick_0[5] | joystick_1[5];
	assign exp_1p = ~{ref_btn.start1, any_bomb, any_fire, dir_out[1], dir_out[0], dir_out[3:2]};
	assign exp_2p = ~{ref_btn.start2, any_bomb, any_fire, dir_out[1], dir_out[0], dir_out[3:2]};

	// Both 6 MHz phases sit on ce_12 cycles, first ce_12 two cycles after reset
	assign exp_ce = {cyc >= 2 && cyc % 2 == 0, cyc % 4 == 2, cyc >= 4 && cyc % 4 == 0};
	assign idle_state = {ip_1p, ip_2p, ip_coin1, vga, audio_out, ce_12, ce_6p, ce_6n, ce_1p79};

	always @(posedge clk_sys) begin
		if (reset) begin
			cyc         <= 0;
			gap179      <= -1;
			audio_count <= 0;
			ref_hs_prev <= 1'b0;
			ref_odd     <= 1'b0;
			exp_vga     <= '0;
		end else begin
			cyc         <= cyc + 1;
			ref_hs_prev <= game_video.hs;
			exp_vga     <= expected_vga(game_video, ref_odd ? scanlines : sl_off);
			if (game_video.hs && !ref_hs_prev)
				ref_odd <= ~ref_odd;
			if (ce_1p79)
				gap179 <= 0;
			else if (gap179 >= 0)
				gap179 <= gap179 + 1;
			if (audio_out && cyc >= 1 && cyc <= 1024)
				audio_count <= audio_count + 1; // First 1024 output bits
		end
	end

	// ==============================
	// Checks
	// ==============================
	a_after_reset: assert property (@(posedge clk_sys) $fell(reset) |->
		idle_state == {7'h7F, 7'h7F, 1'b1, 25'h0})
		else report_mismatch("after reset", 64'({7'h7F, 7'h7F, 1'b1, 25'h0}), 64'(idle_state));

	a_ce_main: assert property (@(posedge clk_sys) disable iff (reset)
		{ce_12, ce_6p, ce_6n} == exp_ce)
		else report_mismatch("clock enables", 64'(exp_ce), 64'({ce_12, ce_6p, ce_6n}));

	a_ce_179: assert property (@(posedge clk_sys) disable iff (reset)
		gap179 >= 0 |-> ce_1p79 == (gap179 == 13))
		else report_mismatch("1.79 MHz enable", 64'(gap179 == 13), 64'(ce_1p79));

	a_ce_179_first: assert property (@(posedge clk_sys) disable iff (reset)
		gap179 < 0 |-> cyc <= 14)
		else stop_with_failure("No 1.79 MHz enable within 14 cycles of reset");

	a_board_inputs: assert property (@(posedge clk_sys) disable iff (reset)
		{ip_1p, ip_2p, ip_coin1} == {exp_1p, exp_2p, ~ref_btn.coin})
		else report_mismatch(test_name, 64'({exp_1p, exp_2p, ~ref_btn.coin}),
			64'({ip_1p, ip_2p, ip_coin1}));

	a_video: assert property (@(posedge clk_sys) disable iff (reset) vga == exp_vga)
		else report_mismatch(test_name, 64'(exp_vga), 64'(vga));

	a_audio: assert property (@(posedge clk_sys) disable iff (reset)
		cyc == 1025 |-> audio_count == int'(game_audio))
		else report_mismatch("audio", 64'(game_audio), 64'(audio_count));

	always @(posedge clk_sys) begin
		cycles_run <= cycles_run + 1;
		if (cycles_run >= TIMEOUT_CYCLES)
			stop_with_failure("Timeout, tests did not finish in the cycle limit");
	end

	// ==============================
	// Stimulus
	// ==============================
	initial begin
		reset       = 1'b1;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = '0;
		joystick_0  = '0;
		joystick_1  = '0;
		rotate      = 1'b1;
		scanlines   = sl_off;
		game_video  = '0;
		game_audio  = '0;
		apply_reset();

		test_name = "clock enables";
		repeat (200) @(negedge clk_sys);

		test_name = "key events";
		repeat (400) begin
			@(negedge clk_sys);
			rng         = xorshift(rng);
			key_strobe  = rng[4];
			key_pressed = rng[5];
			key_code    = KEY_TABLE[rng[3:0]];
		end

		test_name = "joysticks";
		repeat (400) begin
			@(negedge clk_sys);
			rng        = xorshift(rng);
			key_strobe = 1'b0;
			joystick_0 = rng[7:0] & rng[31:24]; // Sparse bits so the OR shows
			joystick_1 = rng[15:8] & rng[23:16];
			rotate     = rng[17];
		end

		test_name = "video";
		for (int mode = 0; mode < 4; mode++) begin
			scanlines = scanline_t'(2'(mode));
			for (int n = 0; n < VIDEO_CYCLES; n++) begin
				@(negedge clk_sys);
				rng               = xorshift(rng);
				game_video.r      = rng[3:0];
				game_video.g      = rng[7:4];
				game_video.b      = rng[11:8];
				game_video.hs     = (n % 25) < 3; // Short line, several hs pulses
				game_video.vs     = rng[12] & rng[13];
				game_video.hblank = rng[14] & rng[15];
				game_video.vblank = rng[16] & rng[17] & rng[18];
			end
		end

		test_name = "audio";
		repeat (3) begin
			rng        = xorshift(rng);
			game_audio = rng[9:0];
			apply_reset();
			repeat (1026) @(negedge clk_sys);
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+logic
logic/arcade_io_pkg.sv
logic/clock_enable_gen.sv
logic/key_decoder.sv
logic/control_mapper.sv
logic/video_output.sv
logic/sigma_delta_dac.sv
logic/cabinet_io_top.sv
verif/cabinet_io_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f verilog.f \
		--top-module cabinet_io_tb -o cabinet_io_sim \
	&& ./obj_dir/cabinet_io_sim \
	|| { echo "simulation run failed"; exit 1; }
